// File: Makefile
.PHONY: simulate clean

simulate:
	verilator --binary --timing --assert -f compile.f --top-module tb_sc_datapath -o tb_sc_datapath
	./obj_dir/tb_sc_datapath | tee sim.log
	grep -q "All tests passed!" sim.log

clean:
	rm -rf obj_dir sim.log

// File: compile.f
+incdir+.
datapath_pkg.sv
regfile.sv
fetch.sv
dispatch.sv
execute.sv
sc_datapath.sv
tb_sc_datapath.sv

// File: datapath_macros.svh
// Width, size and encoding constants for the scalar datapath, included wherever they are needed
`ifndef DATAPATH_MACROS_SVH
`define DATAPATH_MACROS_SVH

// Data and byte address width
`define DP_WORD_W 32

// Architectural register file size
`define DP_NREGS 32

// Register index width, log2 of DP_NREGS
`define DP_REG_AW 5

// Word size in bytes, one pc step
`define DP_WORD_BYTES 4

// Reserved all-ones encoding that stops the machine
`define DP_HALT_INSTR 32'hFFFF_FFFF

`endif

// File: datapath_pkg.sv
// Shared types of the scalar datapath, imported by every stage and the top level
`include "datapath_macros.svh"

package datapath_pkg;

    typedef logic [`DP_WORD_W-1:0] word_t;
    typedef logic [`DP_WORD_W-1:0] addr_t;
    typedef logic [`DP_WORD_W-1:0] instr_t;
    typedef logic [`DP_REG_AW-1:0] regidx_t;

    // RV32I major opcodes that the decoder accepts
    typedef enum logic [6:0] {
        OP_R      = 7'b0110011,
        OP_I      = 7'b0010011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_BRANCH = 7'b1100011
    } opcode_t;

    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR,
        ALU_XOR, ALU_SLT, ALU_SLL, ALU_SRL
    } alu_op_t;

    typedef enum logic [1:0] {BR_NONE, BR_EQ, BR_NE} branch_op_t;

    typedef enum logic [1:0] {MEM_NONE, MEM_LOAD, MEM_STORE} mem_type_t;

    // Decoded control carried from dispatch into execute
    typedef struct packed {
        alu_op_t    alu_op;
        branch_op_t branch_op;
        mem_type_t  mem_type;
        word_t      imm;
        logic       use_imm;
        regidx_t    rd;
        logic       reg_write;
        logic       halt;
        logic       valid;
    } ctrl_t;

    // Fetch to dispatch latch
    typedef struct packed {
        instr_t instr;
        addr_t  pc;
        logic   valid;
    } fd_t;

    // Issue to execute latch
    typedef struct packed {
        ctrl_t ctrl;
        word_t rdat1;
        word_t rdat2;
        addr_t pc;
    } ie_t;

    // Execute to writeback latch
    typedef struct packed {
        word_t   alu_result;
        word_t   load_data;
        regidx_t rd;
        logic    reg_write;
        logic    load;
        logic    halt;
        logic    valid;
    } ew_t;

endpackage

// File: dispatch.sv
// Dispatch stage, decodes the instruction and holds it back on scoreboard hazards
`include "datapath_macros.svh"

module dispatch import datapath_pkg::*; (
    input  logic    CLK,
    input  logic    nrst,
    input  instr_t  instr,
    input  logic    valid,
    input  logic    flush,
    input  logic    wb_en,
    input  regidx_t wb_rd,
    output regidx_t rsel1,
    output regidx_t rsel2,
    output ctrl_t   ctrl,
    output logic    freeze
);
    ctrl_t                dec;
    logic                 use_rs1;
    logic                 use_rs2;
    regidx_t              rd;
    logic [`DP_NREGS-1:0] busy;
    logic [`DP_NREGS-1:0] busy_eff;
    logic [`DP_NREGS-1:0] set_mask;
    logic [`DP_NREGS-1:0] clr_mask;

    // Shared funct3 mapping of R-type and immediate ALU ops
    function automatic alu_op_t alu_from_funct(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b100:  return ALU_XOR;
            3'b101:  return ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    assign rsel1 = instr[19:15];
    assign rsel2 = instr[24:20];
    assign rd    = instr[11:7];

    always_comb begin
        dec     = '0;
        use_rs1 = 1'b0;
        use_rs2 = 1'b0;
        dec.rd  = rd;
        if (instr == `DP_HALT_INSTR) begin
            dec.halt = 1'b1;
        end else begin
            case (instr[6:0])
                OP_R: begin
                    use_rs1       = 1'b1;
                    use_rs2       = 1'b1;
                    dec.alu_op    = alu_from_funct(instr[14:12], instr[30]);
                    dec.reg_write = 1'b1;
                end
                OP_I: begin
                    use_rs1       = 1'b1;
                    dec.alu_op    = alu_from_funct(instr[14:12], 1'b0);
                    dec.imm       = {{20{instr[31]}}, instr[31:20]};
                    dec.use_imm   = 1'b1;
                    dec.reg_write = 1'b1;
                end
                OP_LOAD: begin
                    use_rs1       = 1'b1;
                    dec.imm       = {{20{instr[31]}}, instr[31:20]};
                    dec.use_imm   = 1'b1;
                    dec.mem_type  = MEM_LOAD;
                    dec.reg_write = 1'b1;
                end
                OP_STORE: begin
                    use_rs1      = 1'b1;
                    use_rs2      = 1'b1;
                    dec.imm      = {{20{instr[31]}}, instr[31:25], instr[11:7]};
                    dec.use_imm  = 1'b1;
                    dec.mem_type = MEM_STORE;
                end
                OP_BRANCH: begin
                    use_rs1    = 1'b1;
                    use_rs2    = 1'b1;
                    dec.alu_op = ALU_SUB;
                    dec.imm    = {{19{instr[31]}}, instr[31], instr[7],
                                  instr[30:25], instr[11:8], 1'b0};
                    if (instr[14:12] == 3'b000) begin
                        dec.branch_op = BR_EQ;
                    end else if (instr[14:12] == 3'b001) begin
                        dec.branch_op = BR_NE;
                    end
                end
                default: ;
            endcase
        end
        // x0 never becomes busy
        if (rd == '0) begin
            dec.reg_write = 1'b0;
        end
    end

    // A register cleared by writeback this cycle counts as free
    always_comb begin
        clr_mask = '0;
        if (wb_en) begin
            clr_mask[wb_rd] = 1'b1;
        end
    end

    assign busy_eff = busy & ~clr_mask;
    assign freeze   = valid && ((use_rs1 && busy_eff[rsel1]) ||
                                (use_rs2 && busy_eff[rsel2]) ||
                                (dec.reg_write && busy_eff[rd]));

    always_comb begin
        ctrl       = dec;
        ctrl.valid = valid && !freeze && !flush;
        set_mask   = '0;
        if (ctrl.valid && dec.reg_write) begin
            set_mask[rd] = 1'b1;
        end
    end

    // Set after clear, so a same-cycle release and claim leaves the bit busy
    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            busy <= '0;
        end else begin
            busy <= (busy & ~clr_mask) | set_mask;
        end
    end

endmodule

// File: execute.sv
// Execute stage with the scalar ALU, branch resolution and the load/store unit
module execute import datapath_pkg::*; (
    input  logic  CLK,
    input  logic  nrst,
    input  ie_t   ie,
    input  word_t dmem_load,
    input  logic  dhit,
    output ew_t   ew,
    output logic  flush,
    output addr_t target,
    output logic  mem_wait,
    output logic  dmem_ren,
    output logic  dmem_wen,
    output addr_t dmem_addr,
    output word_t dmem_store
);
    word_t alu_a;
    word_t alu_b;
    word_t alu_out;
    logic  taken;
    logic  mem_op;
    logic  done;

    assign alu_a = ie.rdat1;
    assign alu_b = ie.ctrl.use_imm ? ie.ctrl.imm : ie.rdat2;

    always_comb begin
        case (ie.ctrl.alu_op)
            ALU_ADD: alu_out = alu_a + alu_b;
            ALU_SUB: alu_out = alu_a - alu_b;
            ALU_AND: alu_out = alu_a & alu_b;
            ALU_OR:  alu_out = alu_a | alu_b;
            ALU_XOR: alu_out = alu_a ^ alu_b;
            ALU_SLT: alu_out = word_t'($signed(alu_a) < $signed(alu_b));
            ALU_SLL: alu_out = alu_a << alu_b[4:0];
            default: alu_out = alu_a >> alu_b[4:0];
        endcase
    end

    // Not-taken prediction, so any taken branch redirects
    always_comb begin
        case (ie.ctrl.branch_op)
            BR_EQ:   taken = ie.rdat1 == ie.rdat2;
            BR_NE:   taken = ie.rdat1 != ie.rdat2;
            default: taken = 1'b0;
        endcase
    end

    assign flush  = ie.ctrl.valid && taken;
    assign target = ie.pc + ie.ctrl.imm;

    // Access stays requested until dhit, then done masks the following cycle
    assign mem_op     = ie.ctrl.valid && ie.ctrl.mem_type != MEM_NONE;
    assign mem_wait   = mem_op && !dhit;
    assign dmem_ren   = mem_op && !done && ie.ctrl.mem_type == MEM_LOAD;
    assign dmem_wen   = mem_op && !done && ie.ctrl.mem_type == MEM_STORE;
    assign dmem_addr  = ie.rdat1 + ie.ctrl.imm;
    assign dmem_store = ie.rdat2;

    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            done <= 1'b0;
        end else begin
            done <= mem_op && dhit;
        end
    end

    assign ew.alu_result = alu_out;
    assign ew.load_data  = dmem_load;
    assign ew.rd         = ie.ctrl.rd;
    assign ew.reg_write  = ie.ctrl.valid && ie.ctrl.reg_write;
    assign ew.load       = ie.ctrl.mem_type == MEM_LOAD;
    assign ew.halt       = ie.ctrl.valid && ie.ctrl.halt;
    assign ew.valid      = ie.ctrl.valid;

endmodule

// File: fetch.sv
// Fetch stage, owns the program counter and stops the instruction stream after a halt
`include "datapath_macros.svh"

module fetch import datapath_pkg::*; (
    input  logic   CLK,
    input  logic   nrst,
    input  logic   ihit,
    input  instr_t imem_load,
    input  logic   freeze,
    input  logic   flush,
    input  addr_t  target,
    output addr_t  pc,
    output instr_t instr,
    output logic   fetched_halt
);
    addr_t pc_r;
    logic  stopped;
    logic  accept;

    // An instruction is taken when memory answers and nothing holds the front end
    assign accept = ihit && !freeze && !stopped;

    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            pc_r    <= '0;
            stopped <= 1'b0;
        end else if (flush) begin
            // Redirect wins, and a halt seen on the wrong path is forgotten
            pc_r    <= target;
            stopped <= 1'b0;
        end else if (accept) begin
            if (imem_load == `DP_HALT_INSTR) begin
                stopped <= 1'b1;
            end else begin
                pc_r <= pc_r + addr_t'(`DP_WORD_BYTES);
            end
        end
    end

    assign pc           = pc_r;
    assign instr        = imem_load;
    assign fetched_halt = stopped;

endmodule

// File: regfile.sv
// Scalar register file, two combinational read ports and one clocked write port
`include "datapath_macros.svh"

module regfile import datapath_pkg::*; (
    input  logic    CLK,
    input  logic    nrst,
    input  logic    wen,
    input  regidx_t wsel,
    input  word_t   wdat,
    input  regidx_t rsel1,
    input  regidx_t rsel2,
    output word_t   rdat1,
    output word_t   rdat2
);
    word_t regs [`DP_NREGS];

    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            for (int i = 0; i < `DP_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && wsel != '0) begin
            regs[wsel] <= wdat;
        end
    end

    // Write-through so a register released by writeback can be read in the same cycle
    assign rdat1 = (wen && wsel != '0 && wsel == rsel1) ? wdat : regs[rsel1];
    assign rdat2 = (wen && wsel != '0 && wsel == rsel2) ? wdat : regs[rsel2];

endmodule

// File: sc_datapath.sv
// Top of the four-stage scalar datapath, wires the stages through the pipeline latches
module sc_datapath import datapath_pkg::*; (
    input  logic   CLK,
    input  logic   nrst,
    output addr_t  imem_addr,
    input  instr_t imem_load,
    input  logic   ihit,
    output logic   dmem_ren,
    output logic   dmem_wen,
    output addr_t  dmem_addr,
    output word_t  dmem_store,
    input  word_t  dmem_load,
    input  logic   dhit,
    output logic   halt
);
    fd_t     fd_fetch;
    fd_t     fd_dispatch;
    ie_t     ie_issue;
    ie_t     ie_execute;
    ew_t     ew_execute;
    ew_t     ew_writeback;
    addr_t   pc;
    instr_t  instr;
    logic    fetched_halt;
    logic    freeze;
    logic    flush;
    addr_t   target;
    logic    mem_wait;
    logic    front_hold;
    logic    disp_valid;
    ctrl_t   ctrl;
    regidx_t rsel1;
    regidx_t rsel2;
    word_t   rdat1;
    word_t   rdat2;
    logic    wb_en;
    word_t   wb_data;
    logic    halt_r;

    // A pending memory access holds every earlier stage
    assign front_hold = freeze || mem_wait;
    assign disp_valid = fd_dispatch.valid && !mem_wait;

    fetch u_fetch (
        .CLK(CLK), .nrst(nrst), .ihit(ihit), .imem_load(imem_load),
        .freeze(front_hold), .flush(flush), .target(target),
        .pc(pc), .instr(instr), .fetched_halt(fetched_halt)
    );

    dispatch u_dispatch (
        .CLK(CLK), .nrst(nrst), .instr(fd_dispatch.instr), .valid(disp_valid),
        .flush(flush), .wb_en(wb_en), .wb_rd(ew_writeback.rd),
        .rsel1(rsel1), .rsel2(rsel2), .ctrl(ctrl), .freeze(freeze)
    );

    regfile u_regfile (
        .CLK(CLK), .nrst(nrst), .wen(wb_en), .wsel(ew_writeback.rd), .wdat(wb_data),
        .rsel1(rsel1), .rsel2(rsel2), .rdat1(rdat1), .rdat2(rdat2)
    );

    execute u_execute (
        .CLK(CLK), .nrst(nrst), .ie(ie_execute), .dmem_load(dmem_load), .dhit(dhit),
        .ew(ew_execute), .flush(flush), .target(target), .mem_wait(mem_wait),
        .dmem_ren(dmem_ren), .dmem_wen(dmem_wen),
        .dmem_addr(dmem_addr), .dmem_store(dmem_store)
    );

    assign imem_addr      = pc;
    assign fd_fetch.instr = instr;
    assign fd_fetch.pc    = pc;
    // A word is valid when memory answers and fetch has not stopped on a halt
    assign fd_fetch.valid = ihit && !fetched_halt;

    assign ie_issue.ctrl  = ctrl;
    assign ie_issue.rdat1 = rdat1;
    assign ie_issue.rdat2 = rdat2;
    assign ie_issue.pc    = fd_dispatch.pc;

    // Writeback select
    assign wb_en   = ew_writeback.valid && ew_writeback.reg_write;
    assign wb_data = ew_writeback.load ? ew_writeback.load_data : ew_writeback.alu_result;

    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            fd_dispatch  <= '0;
            ie_execute   <= '0;
            ew_writeback <= '0;
            halt_r       <= 1'b0;
        end else begin
            if (flush) begin
                fd_dispatch.valid <= 1'b0;
            end else if (!front_hold) begin
                // Once dispatched the slot empties unless a new word arrives
                fd_dispatch <= fd_fetch;
            end
            if (!mem_wait) begin
                ie_execute <= ie_issue;
            end
            ew_writeback <= mem_wait ? '0 : ew_execute;
            // Sticky until reset
            if (ew_writeback.valid && ew_writeback.halt) begin
                halt_r <= 1'b1;
            end
        end
    end

    assign halt = halt_r;

endmodule

// File: tb_sc_datapath.sv
// Testbench for sc_datapath, runs random programs and compares the store stream with an ISA model
`include "datapath_macros.svh"

module tb_sc_datapath import datapath_pkg::*; ();
    localparam int NUM_TESTS      = 5;
    localparam int BODY_LEN       = 40;
    localparam int PROG_LEN       = BODY_LEN + 16;
    localparam int TIMEOUT_CYCLES = 20 * PROG_LEN * NUM_TESTS;
    localparam bit [NUM_TESTS-1:0] MEM_ON = 5'b11100;
    localparam bit [NUM_TESTS-1:0] BR_ON  = 5'b11000;

    logic   CLK       = 1'b0;
    logic   nrst      = 1'b0;
    logic   ihit      = 1'b0;
    instr_t imem_load = '0;
    logic   dhit      = 1'b0;
    word_t  dmem_load = '0;
    addr_t  imem_addr;
    logic   dmem_ren;
    logic   dmem_wen;
    addr_t  dmem_addr;
    word_t  dmem_store;
    logic   halt;

    instr_t imem [128];
    word_t  dmem [64];
    word_t  init_mem [64];
    word_t  exp_addr [$];
    word_t  exp_data [$];
    string  test_name [NUM_TESTS] = '{"alu", "hazard", "load_store", "branch", "halt"};
    logic   mem_busy  = 1'b0;
    int     mem_cnt   = 0;
    int     obs_n     = 0;
    int     mon_errs  = 0;
    int     main_errs = 0;
    int     cycles    = 0;
    int     npass     = 0;
    int     nfail     = 0;

    sc_datapath u_sc_datapath (
        .CLK(CLK), .nrst(nrst), .imem_addr(imem_addr), .imem_load(imem_load), .ihit(ihit),
        .dmem_ren(dmem_ren), .dmem_wen(dmem_wen), .dmem_addr(dmem_addr),
        .dmem_store(dmem_store), .dmem_load(dmem_load), .dhit(dhit), .halt(halt)
    );

    initial begin
        forever #10 CLK = ~CLK;
    end

    // RV32I semantics of the ALU subset
    function automatic word_t alu_ref(input logic [2:0] f3, input logic sub, input word_t a,
                                      input word_t b);
        case (f3)
            3'd0:    return sub ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd4:    return a ^ b;
            3'd5:    return a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic gen_program(input bit use_mem, input bit use_br, input int reg_hi);
        int          kind;
        int          k;
        logic [2:0]  f3;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] imm;
        logic [12:0] off;
        logic        alt;
        foreach (imem[i]) imem[i] = `DP_HALT_INSTR;
        for (int p = 0; p < BODY_LEN; p++) begin
            kind = int'($urandom_range(9, 0));
            rd   = 5'($urandom_range(reg_hi, 0));
            rs1  = 5'($urandom_range(reg_hi, 0));
            rs2  = 5'($urandom_range(reg_hi, 0));
            f3   = 3'($urandom_range(7, 0));
            imm  = 12'($urandom);
            // sltu is not in the subset
            if (f3 == 3'd3) f3 = 3'd0;
            alt = (f3 == 3'd0) && imm[0];
            if (use_br && kind == 0) begin
                // Forward only, never past the first closing store
                k = int'($urandom_range(4, 2));
                if (p + k > BODY_LEN) k = BODY_LEN - p;
                off = 13'(4 * k);
                if ($urandom_range(3, 0) == 0) rs2 = rs1;
                imem[p] = {off[12], off[10:5], rs2, rs1, 2'b00, f3[0], off[4:1], off[11],
                           7'b1100011};
            end else if (use_mem && kind < 3) begin
                imm = 12'(4 * $urandom_range(47, 0));
                if (kind == 1) imem[p] = {imm, 5'd0, 3'b010, rd, 7'b0000011};
                else imem[p] = {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], 7'b0100011};
            end else if (kind[0]) begin
                imem[p] = {1'b0, alt, 5'b0, rs2, rs1, f3, rd, 7'b0110011};
            end else begin
                if (f3 == 3'd1 || f3 == 3'd5) imm[11:5] = '0;
                imem[p] = {imm, rs1, f3, rd, 7'b0010011};
            end
        end
        // Dump x1..x15 to the reserved words 48..62, halt follows from the fill
        for (int i = 1; i < 16; i++) begin
            imm = 12'(192 + 4 * (i - 1));
            imem[BODY_LEN + i - 1] = {imm[11:5], 5'(i), 5'd0, 3'b010, imm[4:0], 7'b0100011};
        end
    endtask

    task automatic run_model();
        word_t xr [32];
        word_t mm [64];
        word_t pc;
        word_t ins;
        word_t a;
        word_t b;
        word_t addr;
        foreach (xr[i]) xr[i] = '0;
        mm = init_mem;
        exp_addr.delete();
        exp_data.delete();
        pc  = '0;
        ins = imem[pc[8:2]];
        while (ins != `DP_HALT_INSTR) begin
            a    = xr[ins[19:15]];
            b    = xr[ins[24:20]];
            addr = a + {{20{ins[31]}}, ins[31:20]};
            case (ins[6:0])
                7'b0110011: xr[ins[11:7]] = alu_ref(ins[14:12], ins[30], a, b);
                7'b0010011: xr[ins[11:7]] = alu_ref(ins[14:12], 1'b0, a, addr - a);
                7'b0000011: xr[ins[11:7]] = mm[addr[7:2]];
                7'b0100011: begin
                    addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                    mm[addr[7:2]] = b;
                    exp_addr.push_back(addr);
                    exp_data.push_back(b);
                end
                default: begin
                    if (ins[12] ? a != b : a == b) begin
                        pc = pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8],
                                   1'b0} - 32'd4;
                    end
                end
            endcase
            xr[0] = '0;
            pc    = pc + 32'd4;
            ins   = imem[pc[8:2]];
        end
    endtask

    task automatic apply_reset();
        @(posedge CLK);
        #2 nrst = 1'b0;
        #1;
        assert (halt == 1'b0) else begin
            $display("MISMATCH halt expected 0 got %h", halt);
            main_errs++;
        end
        repeat (16) @(posedge CLK);
        #2 nrst = 1'b1;
    endtask

    // Memory inputs change a fixed delay after the rising edge
    always @(posedge CLK) begin
        #2;
        ihit      = ($urandom_range(3, 0) != 0);
        imem_load = imem[imem_addr[8:2]];
        dhit      = mem_busy && mem_cnt == 0;
        dmem_load = dmem[dmem_addr[7:2]];
    end

    // Data memory model and store monitor, sampled mid-cycle
    always @(negedge CLK) begin
        if (!nrst) begin
            dmem     = init_mem;
            obs_n    = 0;
            mem_busy = 1'b0;
            mem_cnt  = 0;
        end else begin
            assert (!(halt && (dmem_ren || dmem_wen))) else begin
                $display("Data access to %h while halt is high", dmem_addr);
                mon_errs++;
            end
            if (dhit) begin
                mem_busy = 1'b0;
                if (dmem_wen) begin
                    dmem[dmem_addr[7:2]] = dmem_store;
                    if (obs_n >= exp_addr.size()) begin
                        $display("Store to %h beyond the expected store stream", dmem_addr);
                        mon_errs++;
                    end else begin
                        assert (dmem_addr == exp_addr[obs_n]) else begin
                            $display("MISMATCH dmem_addr expected %h got %h",
                                     exp_addr[obs_n], dmem_addr);
                            mon_errs++;
                        end
                        assert (dmem_store == exp_data[obs_n]) else begin
                            $display("MISMATCH dmem_store expected %h got %h",
                                     exp_data[obs_n], dmem_store);
                            mon_errs++;
                        end
                    end
                    obs_n++;
                end
            end else if (mem_busy) begin
                if (mem_cnt > 0) mem_cnt--;
            end else if (dmem_ren || dmem_wen) begin
                // dhit follows 1 to 4 cycles after the request
                mem_busy = 1'b1;
                mem_cnt  = int'($urandom_range(3, 0));
            end
        end
    end

    always @(posedge CLK) begin
        cycles++;
        if (cycles > TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles without halt", cycles);
            $display("Test failures found");
            $finish;
        end
    end

    initial begin
        int errs_before;
        int reg_hi;
        void'($urandom(32'ha524_a673));
        for (int t = 0; t < NUM_TESTS; t++) begin
            errs_before = main_errs + mon_errs;
            reg_hi = (t == 1) ? 3 : ((t == 2 || t == 3) ? 7 : 15);
            gen_program(MEM_ON[t], BR_ON[t], reg_hi);
            foreach (init_mem[i]) init_mem[i] = $urandom;
            run_model();
            apply_reset();
            do begin
                @(posedge CLK);
                #2;
            end while (!halt);
            assert (obs_n == exp_addr.size()) else begin
                $display("Halt rose after %0d of %0d expected stores", obs_n, exp_addr.size());
                main_errs++;
            end
            repeat (8) begin
                @(posedge CLK);
                #2;
                assert (halt) else begin
                    $display("MISMATCH halt expected 1 got %h", halt);
                    main_errs++;
                end
            end
            if (main_errs + mon_errs == errs_before) begin
                npass++;
                $display("Test %0d %s: PASS, %0d stores", t, test_name[t], obs_n);
            end else begin
                nfail++;
                $display("Test %0d %s: FAIL, %0d stores", t, test_name[t], obs_n);
            end
        end
        $display("Summary: %0d tests passed, %0d tests failed", npass, nfail);
        if (nfail == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule
